// ==== ub_pkg.sv ====
// Shared sizes, layer table, bus structs and enums of the patch extraction buffer
// Every other file refers to these by ub_pkg:: scoped names
package ub_pkg;

    localparam int img_dim    = 16;
    localparam int patch_dim  = 7;
    localparam int num_banks  = 4;
    localparam int ram_words  = 64;
    localparam int pix_w      = 32;
    localparam int num_layers = 4;

    localparam int coord_w = $clog2(img_dim);
    localparam int row_w   = $clog2(patch_dim);
    localparam int word_aw = $clog2(ram_words);
    localparam int pix_aw  = $clog2(img_dim * img_dim);
    localparam int layer_w = $clog2(num_layers);

    typedef struct packed {
        logic [2:0] ksize;
        logic [1:0] pad;
    } layer_cfg_t;

    // Kernel and padding per layer
    localparam layer_cfg_t layer_table [num_layers] = '{
        '{ksize: 3'd7, pad: 2'd3},
        '{ksize: 3'd5, pad: 2'd2},
        '{ksize: 3'd3, pad: 2'd1},
        '{ksize: 3'd3, pad: 2'd1}
    };

    typedef struct packed {
        logic               re;
        logic [word_aw-1:0] addr;
    } ram_req_t;

    typedef struct packed {
        logic                              valid;
        logic [num_banks-1:0][pix_w-1:0]   data;
    } ram_rsp_t;

    // Element [0][0] is the top-left pixel
    typedef logic [patch_dim-1:0][patch_dim-1:0][pix_w-1:0] patch_t;

    typedef struct packed {
        logic [coord_w-1:0] row;
        logic [coord_w-1:0] col;
    } pos_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_hold,
        st_done
    } ctrl_state_e;

    typedef enum logic [7:0] {
        reg_ctrl     = 8'h00,
        reg_layer    = 8'h04,
        reg_status   = 8'h08,
        reg_pos      = 8'h0C,
        reg_ram_addr = 8'h10,
        reg_ram_data = 8'h14
    } ub_reg_e;

    // First patch column plus 4 to stay non-negative
    function automatic logic [4:0] col_base(pos_t p, layer_cfg_t c);
        return {1'b0, p.col} + 5'd4 - {3'b000, c.pad};
    endfunction

    // Image row of patch row r (negative above the top edge)
    function automatic logic signed [5:0] img_row(pos_t p, layer_cfg_t c, logic [row_w-1:0] r);
        return $signed({2'b00, p.row}) - $signed({4'b0000, c.pad}) + $signed({3'b000, r});
    endfunction

    function automatic logic row_in_image(logic signed [5:0] r);
        return (r >= 6'sd0) && (r < 6'sd16);
    endfunction

endpackage

// ==== ub_ctrl.sv ====
// APB register file and extraction sequencer of the patch buffer
// Owns the output position and hands fetch requests to the address generator
`timescale 1ns/1ps

module ub_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          next_block,
    input  logic                          patch_ready,
    output ub_pkg::layer_cfg_t            cfg,
    output ub_pkg::pos_t                  pos,
    output logic                          fetch_start,
    output logic                          clear,
    output logic                          wr_en,
    output logic [ub_pkg::pix_aw-1:0]     wr_addr,
    output logic [ub_pkg::pix_w-1:0]      wr_data,
    output logic                          patches_valid,
    output logic                          all_done
);

    ub_pkg::ctrl_state_e            state_q;
    logic [ub_pkg::layer_w-1:0]     layer_q;
    logic [ub_pkg::pix_aw-1:0]      ram_addr_q;
    ub_pkg::pos_t                   pos_q;
    logic                           all_done_q;
    logic                           fetch_q;

    logic apb_wr;
    logic start;
    logic busy;
    logic last_pos;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // Access phase of a write
    assign apb_wr = psel && penable && pwrite;
    assign start  = apb_wr && (paddr == ub_pkg::reg_ctrl) && pwdata[0];

    assign busy          = (state_q == ub_pkg::st_fetch) || (state_q == ub_pkg::st_hold);
    assign patches_valid = (state_q == ub_pkg::st_hold);
    assign all_done      = all_done_q;

    assign last_pos = (pos_q.row == ub_pkg::coord_w'(ub_pkg::img_dim - 1)) &&
                      (pos_q.col == ub_pkg::coord_w'(ub_pkg::img_dim - 1));

    assign cfg         = ub_pkg::layer_table[layer_q];
    assign pos         = pos_q;
    assign fetch_start = fetch_q;
    assign clear       = fetch_q;

    // Pixel writes go straight to the RAM at the access edge
    assign wr_en   = apb_wr && (paddr == ub_pkg::reg_ram_data);
    assign wr_addr = ram_addr_q;
    assign wr_data = pwdata;

    always_comb begin
        prdata = '0;
        case (paddr)
            ub_pkg::reg_layer:    prdata[ub_pkg::layer_w-1:0] = layer_q;
            ub_pkg::reg_status:   prdata[2:0] = {patches_valid, all_done_q, busy};
            ub_pkg::reg_pos:      prdata[2*ub_pkg::coord_w-1:0] = pos_q;
            ub_pkg::reg_ram_addr: prdata[ub_pkg::pix_aw-1:0] = ram_addr_q;
            default:              prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            layer_q    <= '0;
            ram_addr_q <= '0;
        end else begin
            if (apb_wr && (paddr == ub_pkg::reg_layer)) begin
                layer_q <= pwdata[ub_pkg::layer_w-1:0];
            end
            if (apb_wr && (paddr == ub_pkg::reg_ram_addr)) begin
                ram_addr_q <= pwdata[ub_pkg::pix_aw-1:0];
            end else if (wr_en) begin
                ram_addr_q <= ram_addr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ub_pkg::st_idle;
            pos_q      <= '0;
            all_done_q <= 1'b0;
            fetch_q    <= 1'b0;
        end else begin
            fetch_q <= 1'b0;
            case (state_q)
                ub_pkg::st_idle, ub_pkg::st_done: begin
                    if (start) begin
                        pos_q      <= '0;
                        all_done_q <= 1'b0;
                        fetch_q    <= 1'b1;
                        state_q    <= ub_pkg::st_fetch;
                    end
                end
                ub_pkg::st_fetch: begin
                    if (patch_ready) begin
                        state_q <= ub_pkg::st_hold;
                    end
                end
                ub_pkg::st_hold: begin
                    // Patch stays put until the consumer takes it
                    if (next_block) begin
                        if (last_pos) begin
                            all_done_q <= 1'b1;
                            state_q    <= ub_pkg::st_done;
                        end else begin
                            pos_q.col <= pos_q.col + 1'b1;
                            if (pos_q.col == ub_pkg::coord_w'(ub_pkg::img_dim - 1)) begin
                                pos_q.row <= pos_q.row + 1'b1;
                            end
                            fetch_q <= 1'b1;
                            state_q <= ub_pkg::st_fetch;
                        end
                    end
                end
                default: state_q <= ub_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== ub_addr_gen.sv ====
// Turns the current position into two word reads per patch row
// Tags travel one cycle behind the requests so they line up with RAM responses
`timescale 1ns/1ps

module ub_addr_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_start,
    input  ub_pkg::pos_t                pos,
    input  ub_pkg::layer_cfg_t          cfg,
    output ub_pkg::ram_req_t            req,
    output logic [ub_pkg::row_w-1:0]    row_tag,
    output logic                        half_tag,
    output logic                        fetch_done
);

    logic                       active_q;
    logic [ub_pkg::row_w-1:0]   row_q;
    logic                       half_q;

    logic                       issue;
    logic [ub_pkg::row_w-1:0]   cur_row;
    logic                       cur_half;
    logic                       last;
    logic [4:0]                 base;
    logic [2:0]                 word_p;
    logic                       word_ok;
    logic signed [5:0]          row_img;

    always_comb begin
        // First slot is issued in the start cycle itself
        issue    = fetch_start || active_q;
        cur_row  = fetch_start ? '0 : row_q;
        cur_half = fetch_start ? 1'b0 : half_q;
        last     = cur_half && (cur_row == cfg.ksize - 3'd1);

        // word_p is the row word index plus one
        base    = ub_pkg::col_base(pos, cfg);
        word_p  = base[4:2] + {2'b00, cur_half};
        word_ok = (word_p != 3'd0) && (word_p <= 3'd4);
        row_img = ub_pkg::img_row(pos, cfg, cur_row);

        // Rows and words off the image are never read
        req.re   = issue && word_ok && ub_pkg::row_in_image(row_img);
        req.addr = {row_img[3:0], 2'(word_p - 3'd1)};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q   <= 1'b0;
            row_q      <= '0;
            half_q     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            active_q   <= issue && !last;
            fetch_done <= issue && last;
            if (issue) begin
                row_q  <= cur_row + {2'b00, cur_half};
                half_q <= !cur_half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            row_tag  <= cur_row;
            half_tag <= cur_half;
        end
    end

endmodule

// ==== ub_feature_ram.sv ====
// Four-bank feature map store, written pixel by pixel from APB
// A read fetches the same word from every bank with one cycle of latency
`timescale 1ns/1ps

module ub_feature_ram (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  logic [ub_pkg::pix_aw-1:0]   wr_addr,
    input  logic [ub_pkg::pix_w-1:0]    wr_data,
    input  ub_pkg::ram_req_t            req,
    output ub_pkg::ram_rsp_t            rsp
);

    logic [ub_pkg::pix_w-1:0] rd_q [ub_pkg::num_banks];
    logic                     valid_q;

    // Low pixel index bits pick the bank
    for (genvar b = 0; b < ub_pkg::num_banks; b++) begin : g_bank
        logic [ub_pkg::pix_w-1:0] mem [ub_pkg::ram_words];

        always_ff @(posedge clk) begin
            if (wr_en && (wr_addr[1:0] == 2'(b))) begin
                mem[wr_addr[ub_pkg::pix_aw-1:2]] <= wr_data;
            end
            if (req.re) begin
                rd_q[b] <= mem[req.addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.re;
        end
    end

    always_comb begin
        rsp.valid = valid_q;
        for (int b = 0; b < ub_pkg::num_banks; b++) begin
            rsp.data[b] = rd_q[b];
        end
    end

endmodule

// ==== ub_patch_assembler.sv ====
// Places RAM words into the 7 by 7 patch with kernel and border masking
// The patch is cleared at each fetch start so unread rows and columns stay zero
`timescale 1ns/1ps

module ub_patch_assembler (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        fetch_done,
    input  ub_pkg::ram_rsp_t            rsp,
    input  logic [ub_pkg::row_w-1:0]    row_tag,
    input  logic                        half_tag,
    input  ub_pkg::pos_t                pos,
    input  ub_pkg::layer_cfg_t          cfg,
    output ub_pkg::patch_t              patch,
    output logic                        patch_ready
);

    ub_pkg::patch_t patch_q;

    logic [4:0]                                 base;
    logic signed [5:0]                          row_img;
    logic                                       row_keep;
    logic [ub_pkg::patch_dim-1:0][3:0]          span;
    logic [ub_pkg::patch_dim-1:0]               col_keep;
    logic [ub_pkg::patch_dim-1:0][ub_pkg::pix_w-1:0] pick;

    always_comb begin
        base     = ub_pkg::col_base(pos, cfg);
        row_img  = ub_pkg::img_row(pos, cfg, row_tag);
        row_keep = (row_tag < cfg.ksize) && ub_pkg::row_in_image(row_img);

        for (int j = 0; j < ub_pkg::patch_dim; j++) begin
            // Position of patch column j inside the 8-pixel span
            span[j] = {2'b00, base[1:0]} + 4'(j);
            pick[j] = rsp.data[span[j][1:0]];

            // base + j covers image columns 0 to 15 as 4 to 19
            col_keep[j] = (span[j][3:2] == {1'b0, half_tag}) &&
                          (3'(j) < cfg.ksize) &&
                          ((base + 5'(j)) >= 5'd4) &&
                          ((base + 5'(j)) < 5'(ub_pkg::img_dim + 4));
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            patch_q <= '0;
        end else if (rsp.valid && row_keep) begin
            for (int j = 0; j < ub_pkg::patch_dim; j++) begin
                if (col_keep[j]) begin
                    patch_q[row_tag][j] <= pick[j];
                end
            end
        end
    end

    // Last response lands with fetch_done
    always_ff @(posedge clk) begin
        if (rst) begin
            patch_ready <= 1'b0;
        end else begin
            patch_ready <= fetch_done;
        end
    end

    assign patch = patch_q;

endmodule

// ==== ub_top.sv ====
// Top of the layer-aware patch extraction buffer
// APB loads the image and starts extraction, patches leave on the patch port
`timescale 1ns/1ps

module ub_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [7:0]      paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output ub_pkg::patch_t  patch,
    output logic            patches_valid,
    input  logic            next_block,
    output logic            all_done
);

    ub_pkg::layer_cfg_t             cfg;
    ub_pkg::pos_t                   pos;
    logic                           fetch_start;
    logic                           clear;
    logic                           wr_en;
    logic [ub_pkg::pix_aw-1:0]      wr_addr;
    logic [ub_pkg::pix_w-1:0]       wr_data;
    ub_pkg::ram_req_t               req;
    ub_pkg::ram_rsp_t               rsp;
    logic [ub_pkg::row_w-1:0]       row_tag;
    logic                           half_tag;
    logic                           fetch_done;
    logic                           patch_ready;

    ub_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .next_block    (next_block),
        .patch_ready   (patch_ready),
        .cfg           (cfg),
        .pos           (pos),
        .fetch_start   (fetch_start),
        .clear         (clear),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .patches_valid (patches_valid),
        .all_done      (all_done)
    );

    ub_addr_gen u_addr_gen (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .pos         (pos),
        .cfg         (cfg),
        .req         (req),
        .row_tag     (row_tag),
        .half_tag    (half_tag),
        .fetch_done  (fetch_done)
    );

    ub_feature_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .req     (req),
        .rsp     (rsp)
    );

    ub_patch_assembler u_asm (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .fetch_done  (fetch_done),
        .rsp         (rsp),
        .row_tag     (row_tag),
        .half_tag    (half_tag),
        .pos         (pos),
        .cfg         (cfg),
        .patch       (patch),
        .patch_ready (patch_ready)
    );

endmodule

// ==== tb_ub_top.sv ====
// Directed testbench for the patch extraction buffer
// Loads a random image over APB and compares every patch with a behavioral model
`timescale 1ns/1ps

module tb_ub_top;

    localparam int patch_timeout = 100;
    localparam int done_timeout  = 100;

    logic            clk;
    logic            rst;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [7:0]      paddr;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;
    ub_pkg::patch_t  patch;
    logic            patches_valid;
    logic            next_block;
    logic            all_done;

    // Reference image and per-layer kernel and padding
    logic [31:0] img [16][16];
    int kern_tab [4] = '{7, 5, 3, 3};
    int pad_tab  [4] = '{3, 2, 1, 1};

    ub_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .patch         (patch),
        .patches_valid (patches_valid),
        .next_block    (next_block),
        .all_done      (all_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        check(pready, 1'b1, "pready in write access phase");
        check(pslverr, 1'b0, "pslverr in write access phase");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // prdata follows paddr, settled since the last rising edge
        data    = prdata;
        check(pready, 1'b1, "pready in read access phase");
        check(pslverr, 1'b0, "pslverr in read access phase");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_image();
        apb_write(ub_pkg::reg_ram_addr, 32'd0);
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                img[r][c] = $urandom;
                apb_write(ub_pkg::reg_ram_data, img[r][c]);
            end
        end
    endtask

    task automatic wait_patch();
        int cycles;
        cycles = 0;
        while (!patches_valid && cycles < patch_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!patches_valid) begin
            $display("No patch became valid within %0d cycles at %0t ns", patch_timeout, $time);
            abort_run();
        end
    endtask

    task automatic wait_all_done();
        int cycles;
        cycles = 0;
        while (!all_done && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!all_done) begin
            $display("all_done did not rise within %0d cycles at %0t ns", done_timeout, $time);
            abort_run();
        end
    endtask

    // One-cycle consume pulse, called at a falling edge
    task automatic take_patch();
        next_block = 1'b1;
        @(negedge clk);
        next_block = 1'b0;
    endtask

    // Zero outside the kernel or the image, else the image pixel
    function automatic logic [31:0] expected_pixel(int layer, int prow, int pcol, int r, int c);
        int k;
        int ir;
        int ic;
        k  = kern_tab[layer];
        ir = prow - pad_tab[layer] + r;
        ic = pcol - pad_tab[layer] + c;
        if (r >= k || c >= k || ir < 0 || ir > 15 || ic < 0 || ic > 15) begin
            return 32'd0;
        end
        return img[ir][ic];
    endfunction

    task automatic check_patch(input int layer, input int prow, input int pcol);
        for (int r = 0; r < 7; r++) begin
            for (int c = 0; c < 7; c++) begin
                check(patch[r][c], expected_pixel(layer, prow, pcol, r, c),
                      $sformatf("layer %0d pos (%0d,%0d) elem [%0d][%0d]",
                                layer, prow, pcol, r, c));
            end
        end
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        check(patches_valid, 1'b0, "patches_valid after reset");
        check(all_done, 1'b0, "all_done after reset");
        apb_read(ub_pkg::reg_status, rd);
        check(rd[2:0], 3'b000, "status after reset");
        apb_write(ub_pkg::reg_layer, 32'd2);
        apb_read(ub_pkg::reg_layer, rd);
        check(rd, 32'd2, "layer readback");
        apb_write(ub_pkg::reg_ram_addr, 32'h5a);
        apb_read(ub_pkg::reg_ram_addr, rd);
        check(rd, 32'h5a, "ram_addr readback");
    endtask

    task automatic test_layer0_first();
        logic [31:0] exp;
        logic [31:0] rd;
        apb_write(ub_pkg::reg_layer, 32'd0);
        apb_write(ub_pkg::reg_ctrl, 32'd1);
        // The start bit was just written as one
        apb_read(ub_pkg::reg_ctrl, rd);
        check(rd, 32'd0, "ctrl reads zero");
        wait_patch();
        // Padding of 3 leaves the top three rows and left three columns empty
        for (int r = 0; r < 7; r++) begin
            for (int c = 0; c < 7; c++) begin
                exp = (r < 3 || c < 3) ? 32'd0 : img[r-3][c-3];
                check(patch[r][c], exp, $sformatf("layer 0 first patch [%0d][%0d]", r, c));
            end
        end
    endtask

    task automatic test_layer2_interior();
        logic [31:0] exp;
        apb_write(ub_pkg::reg_layer, 32'd2);
        apb_write(ub_pkg::reg_ctrl, 32'd1);
        for (int i = 0; i < 2 * 16 + 5; i++) begin
            wait_patch();
            check_patch(2, i / 16, i % 16);
            take_patch();
        end
        wait_patch();
        // At position (2,5) the 3 by 3 window starts one row up and one column left
        for (int r = 0; r < 7; r++) begin
            for (int c = 0; c < 7; c++) begin
                exp = (r < 3 && c < 3) ? img[1+r][4+c] : 32'd0;
                check(patch[r][c], exp, $sformatf("layer 2 interior [%0d][%0d]", r, c));
            end
        end
    endtask

    task automatic test_back_pressure();
        ub_pkg::patch_t snap;
        int             hold;
        logic [31:0]    rd;
        snap = patch;
        hold = 5 + ($urandom % 16);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check(patches_valid, 1'b1, "patches_valid while held");
            check(patch == snap, 1'b1, "patch stable while held");
        end
        take_patch();
        apb_read(ub_pkg::reg_pos, rd);
        check(rd, 32'h26, "pos after next_block");
    endtask

    task automatic test_full_sweep();
        logic [31:0] rd;
        apb_write(ub_pkg::reg_layer, 32'd1);
        apb_write(ub_pkg::reg_ctrl, 32'd1);
        for (int i = 0; i < 256; i++) begin
            wait_patch();
            check(all_done, 1'b0, "all_done during sweep");
            check_patch(1, i / 16, i % 16);
            take_patch();
        end
        wait_all_done();
        check(patches_valid, 1'b0, "patches_valid after sweep");
        apb_read(ub_pkg::reg_status, rd);
        check(rd[2:0], 3'b010, "status after sweep");
    endtask

    initial begin
        void'($urandom(32'hf318));
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h00;
        pwdata     = 32'd0;
        next_block = 1'b0;

        apply_reset();
        test_registers();
        load_image();
        test_layer0_first();

        // Reset keeps the RAM contents but stops the running sweep
        apply_reset();
        test_layer2_interior();
        test_back_pressure();

        apply_reset();
        test_full_sweep();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== ub_top.f ====
ub_pkg.sv
ub_ctrl.sv
ub_addr_gen.sv
ub_feature_ram.sv
ub_patch_assembler.sv
ub_top.sv
tb_ub_top.sv

// ==== Bender.yml ====
package:
  name: ub_top

sources:
  - ub_pkg.sv
  - ub_ctrl.sv
  - ub_addr_gen.sv
  - ub_feature_ram.sv
  - ub_patch_assembler.sv
  - ub_top.sv
  - target: simulation
    files:
      - tb_ub_top.sv
